// File: rtl/lane_pkg.sv
package lane_pkg;

  // one element as it travels through the lane
  typedef logic [31:0] elem_t;

  // shift amount, wide enough for SEW32
  typedef logic [4:0] shamt_t;

  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  typedef logic [FIFO_AW-1:0] fifo_ptr_t;
  // one extra bit so a full FIFO can be counted
  typedef logic [FIFO_AW:0]   fifo_cnt_t;

  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_e;

  // opcodes seen on the issue port
  typedef enum logic [4:0] {
    OP_ADD, OP_SUB, OP_RSUB, OP_ADC,
    OP_AND, OP_OR, OP_XOR,
    OP_SLL, OP_SRL, OP_SRA,
    OP_SEQ, OP_SNE, OP_SLT, OP_SLTU,
    OP_MIN, OP_MINU, OP_MAX, OP_MAXU,
    OP_MERGE, OP_MOVE
  } lane_op_e;

  // result classes inside the arithmetic unit
  typedef enum logic [2:0] {
    FN_ADDSUB, FN_LOGIC, FN_SHIFT, FN_COMP, FN_MINMAX, FN_MERGE, FN_MOVE
  } alu_fn_e;

  // select encodings for the two-bit sub-operation fields
  localparam logic [1:0] LOGIC_AND = 2'd0;
  localparam logic [1:0] LOGIC_OR  = 2'd1;
  localparam logic [1:0] LOGIC_XOR = 2'd2;

  localparam logic [1:0] SHIFT_SLL = 2'd0;
  localparam logic [1:0] SHIFT_SRL = 2'd1;
  localparam logic [1:0] SHIFT_SRA = 2'd2;

  localparam logic [1:0] CMP_EQ = 2'd0;
  localparam logic [1:0] CMP_NE = 2'd1;
  localparam logic [1:0] CMP_LT = 2'd2;

  typedef struct packed {
    lane_op_e op;
    sew_e     sew;
    logic     mask;
    logic     red_first;
    logic     red;
    elem_t    vs1;
    elem_t    vs2;
  } lane_req_t;

  // decoded entry as stored in the FIFO
  typedef struct packed {
    alu_fn_e    fn;
    sew_e       sew;
    logic       sub;
    logic       rev;
    logic       carry_en;
    logic [1:0] logic_sel;
    logic [1:0] shift_sel;
    logic [1:0] cmp_sel;
    logic       is_signed;
    logic       is_max;
    logic       mask;
    logic       red_first;
    logic       red;
    elem_t      vs1;
    elem_t      vs2;
  } lane_ctrl_t;

endpackage

// File: rtl/lane_issue.sv
`timescale 1ns/1ps

module lane_issue (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 in_req,
  input  lane_pkg::lane_req_t  in_data,
  output logic                 in_ack,
  input  logic                 full,
  output logic                 push,
  output lane_pkg::lane_ctrl_t push_data
);

  import lane_pkg::*;

  typedef enum logic {ISS_IDLE, ISS_ACK} iss_state_e;

  iss_state_e state, state_n;

  // accept only when idle and there is room, otherwise the issuer waits
  assign push   = (state == ISS_IDLE) && in_req && !full;
  assign in_ack = (state == ISS_ACK);

  always_comb begin
    state_n = state;
    case (state)
      ISS_IDLE: if (push) state_n = ISS_ACK;
      ISS_ACK:  if (!in_req) state_n = ISS_IDLE;
      default:  state_n = ISS_IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= ISS_IDLE;
    end else begin
      state <= state_n;
    end
  end

  // opcode decode
  always_comb begin
    push_data           = '0;
    push_data.sew       = in_data.sew;
    push_data.mask      = in_data.mask;
    push_data.red_first = in_data.red_first;
    push_data.red       = in_data.red;
    push_data.vs1       = in_data.vs1;
    push_data.vs2       = in_data.vs2;
    push_data.fn        = FN_ADDSUB;
    case (in_data.op)
      OP_ADD:  push_data.fn = FN_ADDSUB;
      OP_SUB:  push_data.sub = 1'b1;
      OP_RSUB: begin
        push_data.sub = 1'b1;
        push_data.rev = 1'b1;
      end
      OP_ADC:  push_data.carry_en = 1'b1;
      OP_AND: begin
        push_data.fn        = FN_LOGIC;
        push_data.logic_sel = LOGIC_AND;
      end
      OP_OR: begin
        push_data.fn        = FN_LOGIC;
        push_data.logic_sel = LOGIC_OR;
      end
      OP_XOR: begin
        push_data.fn        = FN_LOGIC;
        push_data.logic_sel = LOGIC_XOR;
      end
      OP_SLL: begin
        push_data.fn        = FN_SHIFT;
        push_data.shift_sel = SHIFT_SLL;
      end
      OP_SRL: begin
        push_data.fn        = FN_SHIFT;
        push_data.shift_sel = SHIFT_SRL;
      end
      OP_SRA: begin
        push_data.fn        = FN_SHIFT;
        push_data.shift_sel = SHIFT_SRA;
      end
      OP_SEQ: begin
        push_data.fn      = FN_COMP;
        push_data.cmp_sel = CMP_EQ;
      end
      OP_SNE: begin
        push_data.fn      = FN_COMP;
        push_data.cmp_sel = CMP_NE;
      end
      OP_SLT: begin
        push_data.fn        = FN_COMP;
        push_data.cmp_sel   = CMP_LT;
        push_data.is_signed = 1'b1;
      end
      OP_SLTU: begin
        push_data.fn      = FN_COMP;
        push_data.cmp_sel = CMP_LT;
      end
      OP_MIN: begin
        push_data.fn        = FN_MINMAX;
        push_data.is_signed = 1'b1;
      end
      OP_MINU: push_data.fn = FN_MINMAX;
      OP_MAX: begin
        push_data.fn        = FN_MINMAX;
        push_data.is_signed = 1'b1;
        push_data.is_max    = 1'b1;
      end
      OP_MAXU: begin
        push_data.fn     = FN_MINMAX;
        push_data.is_max = 1'b1;
      end
      OP_MERGE: push_data.fn = FN_MERGE;
      OP_MOVE:  push_data.fn = FN_MOVE;
      default:  push_data.fn = FN_ADDSUB;
    endcase
  end

endmodule

// File: rtl/lane_fifo.sv
`timescale 1ns/1ps

module lane_fifo (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 push,
  input  lane_pkg::lane_ctrl_t push_data,
  input  logic                 pop,
  output lane_pkg::lane_ctrl_t pop_data,
  output logic                 full,
  output logic                 empty
);

  import lane_pkg::*;

  lane_ctrl_t mem [FIFO_DEPTH];
  fifo_ptr_t  wr_ptr, rd_ptr;
  fifo_cnt_t  count;
  logic       do_push, do_pop;

  assign full    = (count == fifo_cnt_t'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // first word falls through
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: rtl/arithmetic_unit.sv
`timescale 1ns/1ps

module arithmetic_unit (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 empty,
  input  lane_pkg::lane_ctrl_t pop_data,
  output logic                 pop,
  output logic                 out_req,
  input  logic                 out_ack,
  output lane_pkg::elem_t      out_data
);

  import lane_pkg::*;

  typedef enum logic [1:0] {AU_IDLE, AU_REQ, AU_WAIT} au_state_e;

  au_state_e state, state_n;

  elem_t  accumulator;
  elem_t  op1_raw, op1, op2;
  elem_t  lhs, rhs, addsub_res;
  elem_t  logic_res, shift_res, cmp_res, mm_res;
  elem_t  raw_res, result;
  shamt_t shamt;
  logic   sext_en, lt, carry;

  // cut a value to SEW bits, then zero or sign extend it back to 32
  function automatic elem_t sew_fit(elem_t v, sew_e sew, logic sext);
    elem_t r;
    case (sew)
      SEW8:    r = {{24{sext & v[7]}}, v[7:0]};
      SEW16:   r = {{16{sext & v[15]}}, v[15:0]};
      SEW32:   r = v;
      default: r = v;
    endcase
    return r;
  endfunction

  // operand preparation
  assign sext_en = pop_data.is_signed ||
                   (pop_data.fn == FN_SHIFT && pop_data.shift_sel == SHIFT_SRA);
  // later reduction steps take the running sum in place of vs1
  assign op1_raw = (pop_data.red && !pop_data.red_first) ? accumulator : pop_data.vs1;
  assign op1     = sew_fit(op1_raw, pop_data.sew, sext_en);
  assign op2     = sew_fit(pop_data.vs2, pop_data.sew, sext_en);

  assign shamt = (pop_data.sew == SEW8)  ? {2'b00, op1[2:0]} :
                 (pop_data.sew == SEW16) ? {1'b0, op1[3:0]} :
                 op1[4:0];

  // rev swaps the operand order of add and sub
  assign lhs        = pop_data.rev ? op1 : op2;
  assign rhs        = pop_data.rev ? op2 : op1;
  assign carry      = pop_data.carry_en & pop_data.mask;
  assign addsub_res = pop_data.sub ? lhs - rhs : lhs + rhs + {31'd0, carry};

  assign lt = pop_data.is_signed ? ($signed(op2) < $signed(op1)) : (op2 < op1);

  always_comb begin
    case (pop_data.logic_sel)
      LOGIC_AND: logic_res = op2 & op1;
      LOGIC_OR:  logic_res = op2 | op1;
      LOGIC_XOR: logic_res = op2 ^ op1;
      default:   logic_res = '0;
    endcase
  end

  // sra relies on op2 already being sign extended from SEW
  always_comb begin
    case (pop_data.shift_sel)
      SHIFT_SLL: shift_res = op2 << shamt;
      SHIFT_SRL: shift_res = op2 >> shamt;
      SHIFT_SRA: shift_res = $signed(op2) >>> shamt;
      default:   shift_res = '0;
    endcase
  end

  always_comb begin
    case (pop_data.cmp_sel)
      CMP_EQ:  cmp_res = {31'd0, op2 == op1};
      CMP_NE:  cmp_res = {31'd0, op2 != op1};
      CMP_LT:  cmp_res = {31'd0, lt};
      default: cmp_res = '0;
    endcase
  end

  always_comb begin
    if (pop_data.is_max) begin
      mm_res = lt ? op1 : op2;
    end else begin
      mm_res = lt ? op2 : op1;
    end
  end

  always_comb begin
    case (pop_data.fn)
      FN_ADDSUB: raw_res = addsub_res;
      FN_LOGIC:  raw_res = logic_res;
      FN_SHIFT:  raw_res = shift_res;
      FN_COMP:   raw_res = cmp_res;
      FN_MINMAX: raw_res = mm_res;
      FN_MERGE:  raw_res = pop_data.mask ? op1 : op2;
      FN_MOVE:   raw_res = op1;
      default:   raw_res = '0;
    endcase
  end

  // results leave zero extended from SEW
  assign result = sew_fit(raw_res, pop_data.sew, 1'b0);

  // output handshake
  assign pop     = (state == AU_IDLE) && !empty;
  assign out_req = (state == AU_REQ);

  always_comb begin
    state_n = state;
    case (state)
      AU_IDLE: if (!empty) state_n = AU_REQ;
      AU_REQ:  if (out_ack) state_n = AU_WAIT;
      AU_WAIT: if (!out_ack) state_n = AU_IDLE;
      default: state_n = AU_IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state       <= AU_IDLE;
      accumulator <= '0;
    end else begin
      state <= state_n;
      if (pop && pop_data.red) begin
        accumulator <= result;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (pop) begin
      out_data <= result;
    end
  end

endmodule

// File: rtl/lane_top.sv
`timescale 1ns/1ps

module lane_top (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                in_req,
  input  lane_pkg::lane_req_t in_data,
  output logic                in_ack,
  output logic                out_req,
  input  logic                out_ack,
  output lane_pkg::elem_t     out_data
);

  import lane_pkg::*;

  logic       push, full, pop, empty;
  lane_ctrl_t push_data, pop_data;

  // decodes and queues incoming requests
  lane_issue lane_issue_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .in_req    (in_req),
    .in_data   (in_data),
    .in_ack    (in_ack),
    .full      (full),
    .push      (push),
    .push_data (push_data)
  );

  lane_fifo lane_fifo_i (
    .CLK       (CLK),
    .nRST      (nRST),
    .push      (push),
    .push_data (push_data),
    .pop       (pop),
    .pop_data  (pop_data),
    .full      (full),
    .empty     (empty)
  );

  arithmetic_unit arithmetic_unit_i (
    .CLK      (CLK),
    .nRST     (nRST),
    .empty    (empty),
    .pop_data (pop_data),
    .pop      (pop),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_data (out_data)
  );

endmodule

// File: bench/lane_assert.sv
`timescale 1ns/1ps

module lane_assert (
  input logic                CLK,
  input logic                nRST,
  input logic                in_req,
  input lane_pkg::lane_req_t in_data,
  input logic                in_ack,
  input logic                out_req,
  input logic                out_ack,
  input lane_pkg::elem_t     out_data,
  input logic                push,
  input logic                full
);

  // request data held until acknowledged
  in_data_stable: assert property (
    @(posedge CLK) disable iff (!nRST) (in_req && !in_ack) |=> $stable(in_data)
  ) else $error("in_data changed while in_req waited for in_ack");

  out_data_stable: assert property (
    @(posedge CLK) disable iff (!nRST) (out_req && $past(out_req)) |-> $stable(out_data)
  ) else $error("out_data changed while out_req was high");

  // a new result waits for the previous ack to drop
  out_req_rise: assert property (
    @(posedge CLK) disable iff (!nRST) $rose(out_req) |-> !$past(out_ack)
  ) else $error("out_req rose while out_ack was high");

  // the FIFO fills only on the edge of a push
  full_after_push: assert property (
    @(posedge CLK) disable iff (!nRST) $rose(full) |-> $past(push)
  ) else $error("FIFO became full without a push");

endmodule

bind lane_top lane_assert lane_assert_i (.*);

// File: bench/lane_tb.sv
`timescale 1ns/1ps

module lane_tb;

  import lane_pkg::*;

  localparam int MAX_VECS = 40;
  localparam int TIMEOUT  = 200;

  // one row of the stimulus table
  typedef struct packed {
    lane_req_t req;
    elem_t     exp;
    logic      bp;
  } vec_t;

  logic      CLK;
  logic      nRST;
  logic      in_req;
  lane_req_t in_data;
  logic      in_ack;
  logic      out_req;
  logic      out_ack;
  elem_t     out_data;

  vec_t   vecs [MAX_VECS];
  string  names [MAX_VECS];
  int     num_vecs;
  int     collected;
  int     pass_count;
  int     fail_count;
  int     max_bp_wait;
  bit     bp_phase;
  integer seed;

  lane_top lane_top_i (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic check_value(string name, elem_t expected, elem_t actual);
    if (expected === actual) begin
      pass_count++;
      $display("PASS  %s result %h", name, actual);
    end else begin
      fail_count++;
      $display("ERROR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic report_failure(string msg);
    fail_count++;
    $display("FAILURE %s", msg);
  endtask

  // flags are {mask, red_first, red}
  task automatic add_vec(string name, lane_op_e op, sew_e sew, logic [2:0] flags,
                         elem_t vs1, elem_t vs2, elem_t exp);
    vec_t v;
    v.req.op  = op;
    v.req.sew = sew;
    {v.req.mask, v.req.red_first, v.req.red} = flags;
    v.req.vs1 = vs1;
    v.req.vs2 = vs2;
    v.exp     = exp;
    v.bp      = bp_phase;
    vecs[num_vecs]  = v;
    names[num_vecs] = name;
    num_vecs++;
  endtask

  task automatic load_table();
    // arithmetic wraps at SEW and ignores upper bits
    add_vec("add8_wrap", OP_ADD, SEW8, 3'b000, 32'hABCD_0001, 32'h1234_56FF, 32'h0000_0000);
    add_vec("add16", OP_ADD, SEW16, 3'b000, 32'h0000_8001, 32'hFFFF_8000, 32'h0000_0001);
    add_vec("sub8", OP_SUB, SEW8, 3'b000, 32'h0000_0007, 32'h0000_FF05, 32'h0000_00FE);
    add_vec("rsub32", OP_RSUB, SEW32, 3'b000, 32'h0000_0100, 32'h0000_0001, 32'h0000_00FF);
    add_vec("adc8_c1", OP_ADC, SEW8, 3'b100, 32'h0000_007F, 32'h0000_0080, 32'h0000_0000);
    add_vec("adc16_c0", OP_ADC, SEW16, 3'b000, 32'h0000_1234, 32'h0000_1111, 32'h0000_2345);
    // logic and shifts
    add_vec("and8", OP_AND, SEW8, 3'b000, 32'hF0F0_F0F0, 32'hFF00_FF3C, 32'h0000_0030);
    add_vec("or16", OP_OR, SEW16, 3'b000, 32'h0000_0F0F, 32'hFFFF_1010, 32'h0000_1F1F);
    add_vec("xor32", OP_XOR, SEW32, 3'b000, 32'hFFFF_0000, 32'h1234_5678, 32'hEDCB_5678);
    add_vec("sll8", OP_SLL, SEW8, 3'b000, 32'h0000_000B, 32'h0000_7711, 32'h0000_0088);
    add_vec("srl16", OP_SRL, SEW16, 3'b000, 32'h0000_0014, 32'hABCD_F000, 32'h0000_0F00);
    add_vec("sra16", OP_SRA, SEW16, 3'b000, 32'h0000_0004, 32'h0000_8010, 32'h0000_F801);
    // signed against unsigned compares and min/max
    add_vec("slt8", OP_SLT, SEW8, 3'b000, 32'h0000_0001, 32'h0000_0080, 32'h0000_0001);
    add_vec("sltu8", OP_SLTU, SEW8, 3'b000, 32'h0000_0001, 32'h0000_0080, 32'h0000_0000);
    add_vec("min8", OP_MIN, SEW8, 3'b000, 32'h0000_0001, 32'h0000_0080, 32'h0000_0080);
    add_vec("minu8", OP_MINU, SEW8, 3'b000, 32'h0000_0001, 32'h0000_0080, 32'h0000_0001);
    add_vec("max8", OP_MAX, SEW8, 3'b000, 32'h0000_0001, 32'h0000_0080, 32'h0000_0001);
    add_vec("maxu8", OP_MAXU, SEW8, 3'b000, 32'h0000_0001, 32'h0000_0080, 32'h0000_0080);
    add_vec("seq16", OP_SEQ, SEW16, 3'b000, 32'h1234_5678, 32'hABCD_5678, 32'h0000_0001);
    add_vec("sne8", OP_SNE, SEW8, 3'b000, 32'h0000_1234, 32'h0000_5634, 32'h0000_0000);
    // merge and move
    add_vec("merge_m1", OP_MERGE, SEW8, 3'b100, 32'hAAAA_AA12, 32'h0000_0034, 32'h0000_0012);
    add_vec("merge_m0", OP_MERGE, SEW16, 3'b000, 32'h0000_1111, 32'hFFFF_2222, 32'h0000_2222);
    add_vec("move8", OP_MOVE, SEW8, 3'b000, 32'h1234_5678, 32'h0000_0000, 32'h0000_0078);
    // four step add reduction ignores vs1 after the first step
    add_vec("red0", OP_ADD, SEW16, 3'b011, 32'h0000_0010, 32'h0000_0005, 32'h0000_0015);
    add_vec("red1", OP_ADD, SEW16, 3'b001, 32'h0000_FFFF, 32'h0000_0020, 32'h0000_0035);
    add_vec("red2", OP_ADD, SEW16, 3'b001, 32'h0000_FFFF, 32'h0000_FFD0, 32'h0000_0005);
    add_vec("red3", OP_ADD, SEW16, 3'b001, 32'h0000_FFFF, 32'h0000_0100, 32'h0000_0105);
    add_vec("after_red", OP_ADD, SEW16, 3'b000, 32'h0000_0001, 32'h0000_0002, 32'h0000_0003);
    // six ops against a held out_ack fill the FIFO
    bp_phase = 1'b1;
    add_vec("bp0_add", OP_ADD, SEW32, 3'b000, 32'h0000_0001, 32'h0000_0100, 32'h0000_0101);
    add_vec("bp1_sub", OP_SUB, SEW32, 3'b000, 32'h0000_0001, 32'h0000_1000, 32'h0000_0FFF);
    add_vec("bp2_xor", OP_XOR, SEW8, 3'b000, 32'h0000_000F, 32'h0000_00FF, 32'h0000_00F0);
    add_vec("bp3_sll", OP_SLL, SEW16, 3'b000, 32'h0000_0001, 32'h0000_8001, 32'h0000_0002);
    add_vec("bp4_maxu", OP_MAXU, SEW32, 3'b000, 32'h0000_0010, 32'h0000_0020, 32'h0000_0020);
    add_vec("bp5_move", OP_MOVE, SEW16, 3'b000, 32'hCAFE_BABE, 32'h0000_0000, 32'h0000_BABE);
  endtask

  function automatic bit phase_start(int i);
    if (!vecs[i].bp) return 1'b0;
    if (i == 0) return 1'b1;
    return !vecs[i-1].bp;
  endfunction

  task automatic run_issuer();
    int waited;
    for (int i = 0; i < num_vecs; i++) begin
      // drain first so the stall comes from the held ack alone
      if (phase_start(i)) begin
        waited = 0;
        while (collected < i && waited < TIMEOUT) begin
          next_cycle();
          waited++;
        end
        if (collected < i) begin
          report_failure("results did not drain before the back-pressure phase");
          return;
        end
      end
      in_data = vecs[i].req;
      in_req  = 1'b1;
      waited  = 0;
      while (!in_ack && waited < TIMEOUT) begin
        next_cycle();
        waited++;
      end
      if (!in_ack) begin
        report_failure($sformatf("input handshake stalled, no in_ack for %s", names[i]));
        return;
      end
      if (vecs[i].bp && waited > max_bp_wait) begin
        max_bp_wait = waited;
      end
      in_req = 1'b0;
      waited = 0;
      while (in_ack && waited < TIMEOUT) begin
        next_cycle();
        waited++;
      end
      if (in_ack) begin
        report_failure($sformatf("input handshake stalled, in_ack stuck high for %s", names[i]));
        return;
      end
    end
  endtask

  task automatic run_collector();
    int waited;
    int delay;
    for (int i = 0; i < num_vecs; i++) begin
      waited = 0;
      while (!out_req && waited < TIMEOUT) begin
        next_cycle();
        waited++;
      end
      if (!out_req) begin
        report_failure($sformatf("output handshake stalled, no out_req for %s", names[i]));
        return;
      end
      check_value(names[i], vecs[i].exp, out_data);
      if (phase_start(i)) begin
        delay = 10;
      end else if (vecs[i].bp) begin
        delay = 1 + {$random(seed)} % 4;
      end else begin
        delay = 1;
      end
      repeat (delay) next_cycle();
      out_ack = 1'b1;
      waited  = 0;
      while (out_req && waited < TIMEOUT) begin
        next_cycle();
        waited++;
      end
      if (out_req) begin
        report_failure($sformatf("output handshake stalled, out_req stuck high for %s", names[i]));
        return;
      end
      out_ack = 1'b0;
      collected++;
    end
  endtask

  initial begin
    seed        = 57468;
    nRST        = 1'b0;
    in_req      = 1'b0;
    in_data     = '0;
    out_ack     = 1'b0;
    num_vecs    = 0;
    collected   = 0;
    pass_count  = 0;
    fail_count  = 0;
    max_bp_wait = 0;
    bp_phase    = 1'b0;
    load_table();
    repeat (8) @(posedge CLK);
    #1;
    nRST = 1'b1;
    fork
      run_issuer();
      run_collector();
    join
    // a full FIFO must have held in_ack off for several cycles
    check_value("bp_stall", 32'd1, (max_bp_wait > 4) ? 32'd1 : 32'd0);
    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: build.f
rtl/lane_pkg.sv
rtl/lane_issue.sv
rtl/lane_fifo.sv
rtl/arithmetic_unit.sv
rtl/lane_top.sv
bench/lane_assert.sv
bench/lane_tb.sv
